// File: verilog/mips_pkg.sv
/* shared widths and encodings for the logic-only MIPS32 subset
   alu codes follow the classic 8-bit operation selector layout */
package mips_pkg;

    // data path widths fixed by the instruction set
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] inst_addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  alu_op_t;

    // number of architectural registers
    localparam int REG_COUNT = 32;

    // alu operation selectors
    localparam alu_op_t ALU_NOP = 8'b0000_0000;
    localparam alu_op_t ALU_AND = 8'b0010_0100;
    localparam alu_op_t ALU_OR  = 8'b0010_0101;
    localparam alu_op_t ALU_XOR = 8'b0010_0110;
    localparam alu_op_t ALU_NOR = 8'b0010_0111;

    // primary opcodes, bits 31:26
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL function codes, bits 5:0
    localparam logic [5:0] FUNCT_AND = 6'b100100;
    localparam logic [5:0] FUNCT_OR  = 6'b100101;
    localparam logic [5:0] FUNCT_XOR = 6'b100110;
    localparam logic [5:0] FUNCT_NOR = 6'b100111;

    // register zero and the all-zero word
    localparam reg_addr_t NOP_REG_ADDR = 5'd0;
    localparam word_t     ZERO_WORD    = 32'h0000_0000;

endpackage

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
/* rom is combinational, inst_i must be valid in the cycle inst_ce_o is high
   no stall input, the pc advances by 4 every enabled cycle */
module fetch_stage (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  mips_pkg::inst_t      inst_i,
    output mips_pkg::inst_addr_t inst_addr_o,
    output logic                 inst_ce_o,
    output mips_pkg::inst_t      if_inst_o
);

    // pc and rom enable
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_ce_o   <= 1'b0;
            inst_addr_o <= '0;
        end else begin
            // enable comes up on the first edge after reset
            inst_ce_o <= 1'b1;
            // pc holds 0 for the first enabled cycle
            if (inst_ce_o) begin
                inst_addr_o <= inst_addr_o + 32'd4;
            end
        end
    end

    // fetch to decode latch
    // an all-zero word decodes as an invalid SPECIAL, i.e. a bubble
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_inst_o <= '0;
        end else if (inst_ce_o) begin
            if_inst_o <= inst_i;
        end else begin
            if_inst_o <= '0;
        end
    end

endmodule

// File: verilog/id.sv
`timescale 1ns/1ps
/* decodes ori/andi/xori/lui and SPECIAL and/or/xor/nor only
   other encodings become bubbles; writes to register zero are dropped here */
module id (
    input  mips_pkg::inst_t     if_inst_i,
    input  mips_pkg::word_t     reg1_data_i,
    input  mips_pkg::word_t     reg2_data_i,
    input  logic                ex_wreg_i,
    input  mips_pkg::reg_addr_t ex_wd_i,
    input  mips_pkg::word_t     ex_wdata_i,
    input  logic                mem_wreg_i,
    input  mips_pkg::reg_addr_t mem_wd_i,
    input  mips_pkg::word_t     mem_wdata_i,
    output logic                reg1_read_o,
    output logic                reg2_read_o,
    output mips_pkg::reg_addr_t reg1_addr_o,
    output mips_pkg::reg_addr_t reg2_addr_o,
    output mips_pkg::alu_op_t   aluop_o,
    output mips_pkg::word_t     reg1_o,
    output mips_pkg::word_t     reg2_o,
    output mips_pkg::reg_addr_t wd_o,
    output logic                wreg_o
);

    // instruction fields
    logic [5:0] op;
    logic [4:0] shamt;
    logic [5:0] funct;
    assign op    = if_inst_i[31:26];
    assign shamt = if_inst_i[10:6];
    assign funct = if_inst_i[5:0];

    mips_pkg::word_t imm;
    logic            inst_valid;

    // operand source, ex forward wins over mem forward
    function automatic mips_pkg::word_t pick_operand(
        input logic                rd_en,
        input mips_pkg::reg_addr_t addr,
        input mips_pkg::word_t     rf_data,
        input mips_pkg::word_t     imm_val,
        input logic                ex_we,
        input mips_pkg::reg_addr_t ex_addr,
        input mips_pkg::word_t     ex_data,
        input logic                mem_we,
        input mips_pkg::reg_addr_t mem_addr,
        input mips_pkg::word_t     mem_data
    );
        if (rd_en && ex_we && (ex_addr == addr)) begin
            return ex_data;
        end else if (rd_en && mem_we && (mem_addr == addr)) begin
            return mem_data;
        end else if (rd_en) begin
            return rf_data;
        end
        // port not read, take the immediate
        return imm_val;
    endfunction

    always_comb begin
        // defaults describe a bubble
        aluop_o     = mips_pkg::ALU_NOP;
        inst_valid  = 1'b0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = if_inst_i[25:21];
        reg2_addr_o = if_inst_i[20:16];
        wd_o        = if_inst_i[15:11];
        imm         = mips_pkg::ZERO_WORD;

        case (op)
            mips_pkg::OP_SPECIAL: begin
                // shamt must be zero for the logic forms
                if (shamt == 5'd0) begin
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    inst_valid  = 1'b1;
                    case (funct)
                        mips_pkg::FUNCT_AND: aluop_o = mips_pkg::ALU_AND;
                        mips_pkg::FUNCT_OR:  aluop_o = mips_pkg::ALU_OR;
                        mips_pkg::FUNCT_XOR: aluop_o = mips_pkg::ALU_XOR;
                        mips_pkg::FUNCT_NOR: aluop_o = mips_pkg::ALU_NOR;
                        default: begin
                            reg1_read_o = 1'b0;
                            reg2_read_o = 1'b0;
                            inst_valid  = 1'b0;
                        end
                    endcase
                end
            end
            mips_pkg::OP_ORI, mips_pkg::OP_ANDI, mips_pkg::OP_XORI: begin
                // rs op zero-extended imm, result to rt
                reg1_read_o = 1'b1;
                wd_o        = if_inst_i[20:16];
                imm         = {16'h0000, if_inst_i[15:0]};
                inst_valid  = 1'b1;
                if (op == mips_pkg::OP_ORI) begin
                    aluop_o = mips_pkg::ALU_OR;
                end else if (op == mips_pkg::OP_ANDI) begin
                    aluop_o = mips_pkg::ALU_AND;
                end else begin
                    aluop_o = mips_pkg::ALU_XOR;
                end
            end
            mips_pkg::OP_LUI: begin
                // lui is $0 | (imm << 16)
                aluop_o     = mips_pkg::ALU_OR;
                reg1_read_o = 1'b1;
                reg1_addr_o = mips_pkg::NOP_REG_ADDR;
                wd_o        = if_inst_i[20:16];
                imm         = {if_inst_i[15:0], 16'h0000};
                inst_valid  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // no write to $0, so forwarding never matches it
    assign wreg_o = inst_valid && (wd_o != mips_pkg::NOP_REG_ADDR);

    always_comb begin
        reg1_o = pick_operand(reg1_read_o, reg1_addr_o, reg1_data_i, imm,
                              ex_wreg_i, ex_wd_i, ex_wdata_i,
                              mem_wreg_i, mem_wd_i, mem_wdata_i);
        reg2_o = pick_operand(reg2_read_o, reg2_addr_o, reg2_data_i, imm,
                              ex_wreg_i, ex_wd_i, ex_wdata_i,
                              mem_wreg_i, mem_wd_i, mem_wdata_i);
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps
/* 32 x 32 register file, register zero always reads 0
   a write in the same cycle as a read of that address is seen by the read */
module regfile (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::word_t     wdata_i,
    input  logic                re1_i,
    input  mips_pkg::reg_addr_t raddr1_i,
    output mips_pkg::word_t     rdata1_o,
    input  logic                re2_i,
    input  mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::word_t     rdata2_o
);

    mips_pkg::word_t regs [mips_pkg::REG_COUNT];

    // write port, $0 is never stored
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < mips_pkg::REG_COUNT; i++) begin
                regs[i] <= mips_pkg::ZERO_WORD;
            end
        end else if (we_i && (waddr_i != mips_pkg::NOP_REG_ADDR)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // both read ports share one description
    logic [1:0]                     re_v;
    mips_pkg::reg_addr_t [1:0]      raddr_v;
    mips_pkg::word_t [1:0]          rdata_v;

    assign re_v    = {re2_i, re1_i};
    assign raddr_v = {raddr2_i, raddr1_i};

    for (genvar p = 0; p < 2; p++) begin : g_rd_port
        always_comb begin
            if (!re_v[p] || (raddr_v[p] == mips_pkg::NOP_REG_ADDR)) begin
                rdata_v[p] = mips_pkg::ZERO_WORD;
            end else if (we_i && (waddr_i == raddr_v[p])) begin
                // writeback bypass for distance 3
                rdata_v[p] = wdata_i;
            end else begin
                rdata_v[p] = regs[raddr_v[p]];
            end
        end
    end

    assign rdata1_o = rdata_v[0];
    assign rdata2_o = rdata_v[1];

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/1ps
/* decode-to-execute latch plus the logic alu; outputs are combinational
   from the latch and feed both the ex forward path and mem */
module ex_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  mips_pkg::alu_op_t   aluop_i,
    input  mips_pkg::word_t     reg1_i,
    input  mips_pkg::word_t     reg2_i,
    input  mips_pkg::reg_addr_t wd_i,
    input  logic                wreg_i,
    output logic                ex_wreg_o,
    output mips_pkg::reg_addr_t ex_wd_o,
    output mips_pkg::word_t     ex_wdata_o
);

    mips_pkg::alu_op_t   aluop_q;
    logic                wreg_q;
    mips_pkg::word_t     reg1_q;
    mips_pkg::word_t     reg2_q;
    mips_pkg::reg_addr_t wd_q;

    // control, reset to a bubble
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aluop_q <= mips_pkg::ALU_NOP;
            wreg_q  <= 1'b0;
        end else begin
            aluop_q <= aluop_i;
            wreg_q  <= wreg_i;
        end
    end

    // operands and destination
    always_ff @(posedge clk_i) begin
        reg1_q <= reg1_i;
        reg2_q <= reg2_i;
        wd_q   <= wd_i;
    end

    // logic alu
    always_comb begin
        case (aluop_q)
            mips_pkg::ALU_OR:  ex_wdata_o = reg1_q | reg2_q;
            mips_pkg::ALU_AND: ex_wdata_o = reg1_q & reg2_q;
            mips_pkg::ALU_XOR: ex_wdata_o = reg1_q ^ reg2_q;
            mips_pkg::ALU_NOR: ex_wdata_o = ~(reg1_q | reg2_q);
            // nop and anything unknown give zero
            default:           ex_wdata_o = mips_pkg::ZERO_WORD;
        endcase
    end

    assign ex_wreg_o = wreg_q;
    assign ex_wd_o   = wd_q;

endmodule

// File: verilog/mem_wb_stage.sv
`timescale 1ns/1ps
/* two latch ranks, no data memory yet; rank 1 feeds the mem forward,
   rank 2 is the register file write port and the retirement trace */
module mem_wb_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                ex_wreg_i,
    input  mips_pkg::reg_addr_t ex_wd_i,
    input  mips_pkg::word_t     ex_wdata_i,
    output logic                mem_wreg_o,
    output mips_pkg::reg_addr_t mem_wd_o,
    output mips_pkg::word_t     mem_wdata_o,
    output logic                wb_we_o,
    output mips_pkg::reg_addr_t wb_waddr_o,
    output mips_pkg::word_t     wb_wdata_o
);

    // write enables of both ranks
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wreg_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            mem_wreg_o <= ex_wreg_i;
            wb_we_o    <= mem_wreg_o;
        end
    end

    // address and data, load/store would hook in between these ranks
    always_ff @(posedge clk_i) begin
        mem_wd_o    <= ex_wd_i;
        mem_wdata_o <= ex_wdata_i;
        wb_waddr_o  <= mem_wd_o;
        wb_wdata_o  <= mem_wdata_o;
    end

endmodule

// File: verilog/mips_core.sv
`timescale 1ns/1ps
/* five-stage logic-subset core, no stalls and no back-pressure
   an instruction fetched in cycle N retires on wb_* in cycle N+4 */
module mips_core (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  mips_pkg::inst_t      inst_i,
    output mips_pkg::inst_addr_t inst_addr_o,
    output logic                 inst_ce_o,
    output logic                 wb_we_o,
    output mips_pkg::reg_addr_t  wb_waddr_o,
    output mips_pkg::word_t      wb_wdata_o
);

    // fetch to decode
    mips_pkg::inst_t     if_inst;
    // decode and register file
    logic                reg1_read;
    logic                reg2_read;
    mips_pkg::reg_addr_t reg1_addr;
    mips_pkg::reg_addr_t reg2_addr;
    mips_pkg::word_t     reg1_data;
    mips_pkg::word_t     reg2_data;
    // decode to execute
    mips_pkg::alu_op_t   aluop;
    mips_pkg::word_t     reg1;
    mips_pkg::word_t     reg2;
    mips_pkg::reg_addr_t wd;
    logic                wreg;
    // forward paths
    logic                ex_wreg;
    mips_pkg::reg_addr_t ex_wd;
    mips_pkg::word_t     ex_wdata;
    logic                mem_wreg;
    mips_pkg::reg_addr_t mem_wd;
    mips_pkg::word_t     mem_wdata;

    fetch_stage u_fetch (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .inst_ce_o   (inst_ce_o),
        .if_inst_o   (if_inst)
    );

    id u_id (
        .if_inst_i   (if_inst),
        .reg1_data_i (reg1_data),
        .reg2_data_i (reg2_data),
        .ex_wreg_i   (ex_wreg),
        .ex_wd_i     (ex_wd),
        .ex_wdata_i  (ex_wdata),
        .mem_wreg_i  (mem_wreg),
        .mem_wd_i    (mem_wd),
        .mem_wdata_i (mem_wdata),
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr),
        .reg2_addr_o (reg2_addr),
        .aluop_o     (aluop),
        .reg1_o      (reg1),
        .reg2_o      (reg2),
        .wd_o        (wd),
        .wreg_o      (wreg)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (wb_we_o),
        .waddr_i  (wb_waddr_o),
        .wdata_i  (wb_wdata_o),
        .re1_i    (reg1_read),
        .raddr1_i (reg1_addr),
        .rdata1_o (reg1_data),
        .re2_i    (reg2_read),
        .raddr2_i (reg2_addr),
        .rdata2_o (reg2_data)
    );

    ex_stage u_ex (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .aluop_i    (aluop),
        .reg1_i     (reg1),
        .reg2_i     (reg2),
        .wd_i       (wd),
        .wreg_i     (wreg),
        .ex_wreg_o  (ex_wreg),
        .ex_wd_o    (ex_wd),
        .ex_wdata_o (ex_wdata)
    );

    mem_wb_stage u_mem_wb (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .ex_wreg_i   (ex_wreg),
        .ex_wd_i     (ex_wd),
        .ex_wdata_i  (ex_wdata),
        .mem_wreg_o  (mem_wreg),
        .mem_wd_o    (mem_wd),
        .mem_wdata_o (mem_wdata),
        .wb_we_o     (wb_we_o),
        .wb_waddr_o  (wb_waddr_o),
        .wb_wdata_o  (wb_wdata_o)
    );

endmodule

// File: verif/mips_core_sva.sv
`timescale 1ns/1ps
/* bound into mips_core; each failed assertion also bumps fail_count */
module mips_core_sva (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input mips_pkg::inst_addr_t inst_addr_i,
    input logic                 inst_ce_i,
    input logic                 wb_we_i,
    input mips_pkg::reg_addr_t  wb_waddr_i,
    input mips_pkg::word_t      wb_wdata_i
);

    int fail_count = 0;

    // one word per enabled cycle
    a_pc_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (inst_ce_i && $past(inst_ce_i)) |-> (inst_addr_i == $past(inst_addr_i) + 32'd4))
    else begin
        fail_count++;
        $error("inst_addr_o did not advance by 4");
    end

    // $0 writes are cancelled in decode
    a_wb_not_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_we_i |-> (wb_waddr_i != mips_pkg::NOP_REG_ADDR))
    else begin
        fail_count++;
        $error("write to register zero reached writeback");
    end

    a_wb_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_we_i |-> !$isunknown({wb_waddr_i, wb_wdata_i}))
    else begin
        fail_count++;
        $error("unknown value on the writeback port");
    end

endmodule

bind mips_core mips_core_sva u_sva (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .inst_addr_i (inst_addr_o),
    .inst_ce_i   (inst_ce_o),
    .wb_we_i     (wb_we_o),
    .wb_waddr_i  (wb_waddr_o),
    .wb_wdata_i  (wb_wdata_o)
);

// File: verif/mips_core_tb.sv
`timescale 1ns/1ps
/* random-program testbench, rom is a queue indexed by pc/4 and reads zero past the end
   assumes no stalls: every fetched word retires on wb_* exactly 4 cycles later */
module mips_core_tb;

    logic                 clk_i;
    logic                 arst_n_i;
    mips_pkg::inst_t      inst_i;
    mips_pkg::inst_addr_t inst_addr_o;
    logic                 inst_ce_o;
    logic                 wb_we_o;
    mips_pkg::reg_addr_t  wb_waddr_o;
    mips_pkg::word_t      wb_wdata_o;

    // program and expected retirement, one entry per instruction
    mips_pkg::inst_t     prog[$];
    logic                exp_we[$];
    mips_pkg::reg_addr_t exp_addr[$];
    mips_pkg::word_t     exp_data[$];
    // architectural registers of the model
    mips_pkg::word_t     model_regs[32];

    mips_core UUT (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .inst_ce_o   (inst_ce_o),
        .wb_we_o     (wb_we_o),
        .wb_waddr_o  (wb_waddr_o),
        .wb_wdata_o  (wb_wdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t exp,
                              input mips_pkg::word_t act);
        if (act !== exp) begin
            report_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input mips_pkg::reg_addr_t exp,
                              input mips_pkg::reg_addr_t act);
        if (act !== exp) begin
            report_error($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_inst_addr(input string name, input mips_pkg::inst_addr_t exp,
                                   input mips_pkg::inst_addr_t act);
        if (act !== exp) begin
            report_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_error($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
        end
    endtask

    // i-type word: op rs rt imm
    function automatic mips_pkg::inst_t imm_inst(input logic [5:0] op,
                                                 input mips_pkg::reg_addr_t rs,
                                                 input mips_pkg::reg_addr_t rt,
                                                 input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // SPECIAL word, shamt always zero
    function automatic mips_pkg::inst_t reg_inst(input logic [5:0] funct,
                                                 input mips_pkg::reg_addr_t rs,
                                                 input mips_pkg::reg_addr_t rt,
                                                 input mips_pkg::reg_addr_t rd);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    // registers 0..7 only, keeps hazards dense
    function automatic mips_pkg::reg_addr_t rand_reg();
        return {2'b00, 3'($urandom())};
    endfunction

    // appends one word to the rom and runs it on the model in program order
    task automatic add_inst(input mips_pkg::inst_t ins);
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t dst;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     res;
        logic                we;
        rs  = ins[25:21];
        rt  = ins[20:16];
        a   = model_regs[rs];
        b   = model_regs[rt];
        dst = rt;
        res = '0;
        we  = 1'b1;
        case (ins[31:26])
            mips_pkg::OP_ORI:  res = a | {16'h0000, ins[15:0]};
            mips_pkg::OP_ANDI: res = a & {16'h0000, ins[15:0]};
            mips_pkg::OP_XORI: res = a ^ {16'h0000, ins[15:0]};
            mips_pkg::OP_LUI:  res = {ins[15:0], 16'h0000};
            mips_pkg::OP_SPECIAL: begin
                dst = ins[15:11];
                // nonzero shamt is not a logic form
                we  = (ins[10:6] == 5'd0);
                case (ins[5:0])
                    mips_pkg::FUNCT_AND: res = a & b;
                    mips_pkg::FUNCT_OR:  res = a | b;
                    mips_pkg::FUNCT_XOR: res = a ^ b;
                    mips_pkg::FUNCT_NOR: res = ~(a | b);
                    default:             we = 1'b0;
                endcase
            end
            default: we = 1'b0;
        endcase
        // $0 is never written, so it keeps reading zero
        if (dst == 5'd0) begin
            we = 1'b0;
        end
        if (we) begin
            model_regs[dst] = res;
        end
        prog.push_back(ins);
        exp_we.push_back(we);
        exp_addr.push_back(dst);
        exp_data.push_back(res);
    endtask

    // producer of $2, then d-1 fillers, then consumers on port 1 and port 2
    task automatic add_directed_chains();
        for (int d = 1; d <= 3; d++) begin
            add_inst(imm_inst(mips_pkg::OP_LUI, 5'd0, 5'd2, 16'($urandom())));
            for (int f = 1; f < d; f++) begin
                add_inst(imm_inst(mips_pkg::OP_ORI, 5'd0, 5'd5, 16'($urandom())));
            end
            add_inst(imm_inst(mips_pkg::OP_ORI, 5'd2, 5'd2, 16'($urandom())));
            for (int f = 1; f < d; f++) begin
                add_inst(imm_inst(mips_pkg::OP_XORI, 5'd6, 5'd6, 16'($urandom())));
            end
            add_inst(reg_inst(mips_pkg::FUNCT_AND, 5'd5, 5'd2, 5'd3));
        end
        // $2 in both ex and mem, the newer value must win
        add_inst(imm_inst(mips_pkg::OP_ORI, 5'd0, 5'd2, 16'h0001));
        add_inst(imm_inst(mips_pkg::OP_ORI, 5'd0, 5'd2, 16'h0002));
        add_inst(reg_inst(mips_pkg::FUNCT_OR, 5'd2, 5'd2, 5'd3));
        // writes to $0 dropped, later reads of $0 see zero
        add_inst(imm_inst(mips_pkg::OP_ORI, 5'd2, 5'd0, 16'hffff));
        add_inst(reg_inst(mips_pkg::FUNCT_NOR, 5'd0, 5'd0, 5'd4));
        add_inst(reg_inst(mips_pkg::FUNCT_XOR, 5'd3, 5'd0, 5'd0));
        add_inst(imm_inst(mips_pkg::OP_ANDI, 5'd0, 5'd4, 16'h1234));
    endtask

    // eight legal forms, roughly one in seventeen invalid
    task automatic add_random_inst();
        int unsigned sel;
        logic [15:0] imm;
        sel = $urandom_range(16, 0);
        imm = 16'($urandom());
        if (sel == 16) begin
            // opcodes 0x20..0x2f are loads and stores, not decoded here
            add_inst({2'b10, 4'($urandom()), rand_reg(), rand_reg(), imm});
        end else begin
            case (sel % 8)
                0: add_inst(imm_inst(mips_pkg::OP_ORI, rand_reg(), rand_reg(), imm));
                1: add_inst(imm_inst(mips_pkg::OP_ANDI, rand_reg(), rand_reg(), imm));
                2: add_inst(imm_inst(mips_pkg::OP_XORI, rand_reg(), rand_reg(), imm));
                3: add_inst(imm_inst(mips_pkg::OP_LUI, 5'd0, rand_reg(), imm));
                4: add_inst(reg_inst(mips_pkg::FUNCT_AND, rand_reg(), rand_reg(), rand_reg()));
                5: add_inst(reg_inst(mips_pkg::FUNCT_OR, rand_reg(), rand_reg(), rand_reg()));
                6: add_inst(reg_inst(mips_pkg::FUNCT_XOR, rand_reg(), rand_reg(), rand_reg()));
                default: add_inst(reg_inst(mips_pkg::FUNCT_NOR, rand_reg(), rand_reg(),
                                           rand_reg()));
            endcase
        end
    endtask

    // combinational rom with enable
    function automatic mips_pkg::inst_t rom_word(input mips_pkg::inst_addr_t addr,
                                                 input logic ce);
        int idx;
        idx = int'(addr[31:2]);
        if (!ce || (idx >= prog.size())) begin
            return '0;
        end
        return prog[idx];
    endfunction

    initial begin
        int                   n_cycles;
        int                   idx;
        logic                 seen;
        mips_pkg::inst_addr_t pc_exp;
        arst_n_i = 1'b0;
        inst_i   = '0;
        void'($urandom(32'hb1593b6d));
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        add_directed_chains();
        repeat (300) add_random_inst();
        // zero words drain the pipeline
        repeat (4) add_inst('0);

        // reset held over 8 rising edges
        for (int i = 0; i < 8; i++) begin
            @(negedge clk_i);
            check_flag("reset inst_ce_o", 1'b0, inst_ce_o);
            check_flag("reset wb_we_o", 1'b0, wb_we_o);
            check_inst_addr("reset inst_addr_o", '0, inst_addr_o);
        end
        arst_n_i = 1'b1;
        #10;
        check_flag("release inst_ce_o", 1'b0, inst_ce_o);
        check_flag("release wb_we_o", 1'b0, wb_we_o);
        check_inst_addr("release inst_addr_o", '0, inst_addr_o);

        // first enabled cycle, bounded
        seen = 1'b0;
        for (int t = 0; (t < 10) && !seen; t++) begin
            @(negedge clk_i);
            seen = inst_ce_o;
        end
        if (!seen) begin
            report_error("timeout: inst_ce_o never rose after reset release");
        end

        // cycle c fetches word c and retires word c-4
        pc_exp   = '0;
        n_cycles = prog.size() + 4;
        for (int c = 0; c < n_cycles; c++) begin
            if (c > 0) begin
                @(negedge clk_i);
            end
            if (UUT.u_sva.fail_count != 0) begin
                report_error("a bound assertion on mips_core failed");
            end
            check_flag("run inst_ce_o", 1'b1, inst_ce_o);
            check_inst_addr("fetch inst_addr_o", pc_exp, inst_addr_o);
            pc_exp = pc_exp + 32'd4;
            if (c < 4) begin
                check_flag("pipeline fill wb_we_o", 1'b0, wb_we_o);
            end else begin
                idx = c - 4;
                check_flag($sformatf("inst %0d wb_we_o", idx), exp_we[idx], wb_we_o);
                if (exp_we[idx]) begin
                    check_addr($sformatf("inst %0d wb_waddr_o", idx), exp_addr[idx], wb_waddr_o);
                    check_word($sformatf("inst %0d wb_wdata_o", idx), exp_data[idx], wb_wdata_o);
                end
            end
            inst_i = rom_word(inst_addr_o, inst_ce_o);
        end

        if (UUT.u_sva.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
verilog/mips_pkg.sv
verilog/fetch_stage.sv
verilog/id.sv
verilog/regfile.sv
verilog/ex_stage.sv
verilog/mem_wb_stage.sv
verilog/mips_core.sv
verif/mips_core_sva.sv
verif/mips_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mips_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mips_core_tb -Mdir obj_dir -o mips_core_sim \
    -f all.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status, see build.log"
    exit 1
fi

# error limit raised so assertion failures reach the testbench
./obj_dir/mips_core_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
fi

if grep -qx "Simulation passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1
